// File: common/core_pkg.sv
// RV64I subset only: no CSRs, no compressed or FP, unknown opcodes decode as no-ops
package core_pkg;

  localparam int XLEN   = 64;
  localparam int REG_AW = 5;

  // one instruction walks through all five phases
  typedef enum logic [2:0] {
    PH_FETCH  = 3'd0,
    PH_DECODE = 3'd1,
    PH_EXEC   = 3'd2,
    PH_MEM    = 3'd3,
    PH_WB     = 3'd4
  } phase_e;

  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OPIMM  = 7'h13;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  // custom halt, x10 low byte is the exit code
  localparam logic [6:0] OPC_TRAP   = 7'h6b;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_W   = 3'b010;
  localparam logic [2:0] F3_D   = 3'b011;

  // memory access kind carried from decode to mem
  localparam logic [2:0] MEM_NONE = 3'd0;
  localparam logic [2:0] MEM_LD   = 3'd1;
  localparam logic [2:0] MEM_LW   = 3'd2;
  localparam logic [2:0] MEM_SD   = 3'd3;
  localparam logic [2:0] MEM_SW   = 3'd4;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS
  } alu_op_e;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_itype_t;

  // R-type shares this layout, funct7 doubles as imm_hi and rd as imm_lo
  typedef struct packed {
    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_stype_t;

  typedef union packed {
    inst_itype_t i;
    inst_stype_t s;
  } inst_word_u;

endpackage

// File: logic/phase_ctrl.sv
// fixed five-cycle sequence with no stall input; a trap parks the core in decode for good
`timescale 1ns/1ps

module phase_ctrl import core_pkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   trap_dec_i,
  output phase_e phase_o,
  output logic   wb_phase_o,
  output logic   halted_o
);

  phase_e phase_q;
  logic   halted_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      phase_q  <= PH_FETCH;
      halted_q <= 1'b0;
    end else if (!halted_q) begin
      case (phase_q)
        PH_FETCH:  phase_q <= PH_DECODE;
        PH_DECODE: phase_q <= PH_EXEC;
        PH_EXEC:   phase_q <= PH_MEM;
        PH_MEM:    phase_q <= PH_WB;
        PH_WB: begin
          if (trap_dec_i) begin
            // decode re-reads the latched trap word, no side effects there
            phase_q  <= PH_DECODE;
            halted_q <= 1'b1;
          end else begin
            phase_q <= PH_FETCH;
          end
        end
        default:   phase_q <= PH_FETCH;
      endcase
    end
  end

  assign phase_o    = phase_q;
  assign wb_phase_o = (phase_q == PH_WB) && !halted_q;
  assign halted_o   = halted_q;

  a_phase_legal: assert property (@(posedge clock) disable iff (reset)
    phase_q inside {PH_FETCH, PH_DECODE, PH_EXEC, PH_MEM, PH_WB});

endmodule

// File: core/if_stage.sv
// instruction port must answer within the fetch cycle; pc moves only at write-back
`timescale 1ns/1ps

module if_stage import core_pkg::*; #(
  parameter logic [XLEN-1:0] PC_START = 64'h0000_0000_8000_0000
) (
  input  logic            clock,
  input  logic            reset,
  input  phase_e          phase_i,
  input  logic            br_taken_i,
  input  logic [XLEN-1:0] br_target_i,
  input  logic [31:0]     imem_data_i,
  output logic [XLEN-1:0] imem_addr_o,
  output logic [XLEN-1:0] pc_o,
  output inst_word_u      inst_o
);

  logic [XLEN-1:0] pc_q;
  inst_word_u      inst_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= PC_START;
    end else if (phase_i == PH_WB) begin
      pc_q <= br_taken_i ? br_target_i : pc_q + 64'd4;
    end
  end

  // instruction word held for the rest of the instruction
  always_ff @(posedge clock) begin
    if (phase_i == PH_FETCH) begin
      inst_q <= imem_data_i;
    end
  end

  assign imem_addr_o = pc_q;
  assign pc_o        = pc_q;
  assign inst_o      = inst_q;

endmodule

// File: core/id_stage.sv
// decodes only the listed RV64I subset; anything else becomes a no-op without write-back
`timescale 1ns/1ps

module id_stage import core_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  phase_e            phase_i,
  input  inst_word_u        inst_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic [XLEN-1:0]   rs1_data_i,
  input  logic [XLEN-1:0]   rs2_data_i,
  output logic [REG_AW-1:0] rs1_o,
  output logic [REG_AW-1:0] rs2_o,
  output logic [REG_AW-1:0] rd_o,
  output alu_op_e           alu_op_o,
  output logic [XLEN-1:0]   op_a_o,
  output logic [XLEN-1:0]   op_b_o,
  output logic [XLEN-1:0]   store_data_o,
  output logic [XLEN-1:0]   imm_o,
  output logic [2:0]        mem_kind_o,
  output logic              is_branch_o,
  output logic              is_jal_o,
  output logic              rd_wen_o,
  output logic              trap_o
);

  logic [XLEN-1:0] imm_itype, imm_stype, imm_btype, imm_jtype, imm_sel;
  logic [XLEN-1:0] op_a_d, op_b_d;
  alu_op_e         alu_d;
  logic [2:0]      kind_d;
  logic            wen_d, br_d, jal_d, use_rs2;

  assign rs1_o = inst_i.s.rs1;
  assign rs2_o = inst_i.s.rs2;

  assign imm_itype = {{52{inst_i.i.imm[11]}}, inst_i.i.imm};
  assign imm_stype = {{52{inst_i.s.funct7[6]}}, inst_i.s.funct7, inst_i.s.rd};
  // B and J offsets are scattered over the same two views
  assign imm_btype = {{52{inst_i.s.funct7[6]}}, inst_i.s.rd[0], inst_i.s.funct7[5:0],
                      inst_i.s.rd[4:1], 1'b0};
  assign imm_jtype = {{44{inst_i.i.imm[11]}}, inst_i.i.rs1, inst_i.i.funct3,
                      inst_i.i.imm[0], inst_i.i.imm[10:1], 1'b0};

  always_comb begin
    alu_d   = ALU_PASS;
    kind_d  = MEM_NONE;
    wen_d   = 1'b0;
    br_d    = 1'b0;
    jal_d   = 1'b0;
    use_rs2 = 1'b0;
    imm_sel = imm_itype;
    case (inst_i.i.opcode)
      OPC_OP: begin
        use_rs2 = 1'b1;
        wen_d   = 1'b1;
        case (inst_i.s.funct3)
          F3_ADD:  alu_d = inst_i.s.funct7[5] ? ALU_SUB : ALU_ADD;
          F3_SLT:  alu_d = ALU_SLT;
          F3_XOR:  alu_d = ALU_XOR;
          F3_OR:   alu_d = ALU_OR;
          F3_AND:  alu_d = ALU_AND;
          default: wen_d = 1'b0;
        endcase
      end
      OPC_OPIMM: begin
        alu_d = ALU_ADD;
        wen_d = (inst_i.i.funct3 == F3_ADD);
      end
      OPC_LOAD: begin
        alu_d = ALU_ADD;
        if (inst_i.i.funct3 == F3_D) kind_d = MEM_LD;
        if (inst_i.i.funct3 == F3_W) kind_d = MEM_LW;
        wen_d = (kind_d != MEM_NONE);
      end
      OPC_STORE: begin
        alu_d   = ALU_ADD;
        imm_sel = imm_stype;
        if (inst_i.s.funct3 == F3_D) kind_d = MEM_SD;
        if (inst_i.s.funct3 == F3_W) kind_d = MEM_SW;
      end
      OPC_BRANCH: begin
        br_d    = 1'b1;
        use_rs2 = 1'b1;
        imm_sel = imm_btype;
      end
      OPC_JAL: begin
        alu_d   = ALU_ADD;
        jal_d   = 1'b1;
        wen_d   = 1'b1;
        imm_sel = imm_jtype;
      end
      default: ;
    endcase
  end

  // jal links through the ALU as pc + 4
  assign op_a_d = jal_d ? pc_i : rs1_data_i;
  assign op_b_d = jal_d ? 64'd4 : (use_rs2 ? rs2_data_i : imm_sel);

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_op_o    <= ALU_PASS;
      mem_kind_o  <= MEM_NONE;
      is_branch_o <= 1'b0;
      is_jal_o    <= 1'b0;
      rd_wen_o    <= 1'b0;
      trap_o      <= 1'b0;
    end else if (phase_i == PH_DECODE) begin
      alu_op_o    <= alu_d;
      mem_kind_o  <= kind_d;
      is_branch_o <= br_d;
      is_jal_o    <= jal_d;
      rd_wen_o    <= wen_d && (inst_i.i.rd != '0);
      trap_o      <= (inst_i.i.opcode == OPC_TRAP);
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == PH_DECODE) begin
      rd_o         <= inst_i.i.rd;
      op_a_o       <= op_a_d;
      op_b_o       <= op_b_d;
      store_data_o <= rs2_data_i;
      imm_o        <= imm_sel;
    end
  end

endmodule

// File: core/exe_stage.sv
// only beq and bne are resolved; other branch funct3 values fall through
`timescale 1ns/1ps

module exe_stage import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  phase_e          phase_i,
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            is_branch_i,
  input  logic            is_jal_i,
  input  logic [2:0]      funct3_i,
  output logic [XLEN-1:0] result_o,
  output logic            br_taken_o,
  output logic [XLEN-1:0] br_target_o
);

  logic [XLEN-1:0] alu_res;
  logic            op_eq;
  logic            cond_taken;

  always_comb begin
    case (alu_op_i)
      ALU_ADD: alu_res = op_a_i + op_b_i;
      ALU_SUB: alu_res = op_a_i - op_b_i;
      ALU_AND: alu_res = op_a_i & op_b_i;
      ALU_OR:  alu_res = op_a_i | op_b_i;
      ALU_XOR: alu_res = op_a_i ^ op_b_i;
      ALU_SLT: alu_res = {63'd0, $signed(op_a_i) < $signed(op_b_i)};
      default: alu_res = op_b_i;
    endcase
  end

  // branch operands arrive as rs1 and rs2
  assign op_eq = (op_a_i == op_b_i);

  always_comb begin
    case (funct3_i)
      F3_BEQ:  cond_taken = op_eq;
      F3_BNE:  cond_taken = !op_eq;
      default: cond_taken = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      br_taken_o <= 1'b0;
    end else if (phase_i == PH_EXEC) begin
      br_taken_o <= is_jal_i || (is_branch_i && cond_taken);
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == PH_EXEC) begin
      result_o    <= alu_res;
      br_target_o <= pc_i + imm_i;
    end
  end

endmodule

// File: core/mem_stage.sv
// data port returns read data one cycle later with no stall; word accesses assume alignment
`timescale 1ns/1ps

module mem_stage import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  phase_e          phase_i,
  input  logic [2:0]      mem_kind_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] store_data_i,
  input  logic [XLEN-1:0] alu_result_i,
  input  logic            rd_wen_i,
  output logic            dmem_ren_o,
  output logic            dmem_wen_o,
  output logic [XLEN-1:0] dmem_addr_o,
  output logic [XLEN-1:0] dmem_wdata_o,
  output logic [7:0]      dmem_wmask_o,
  input  logic [XLEN-1:0] dmem_rdata_i,
  output logic            wb_wen_o,
  output logic [XLEN-1:0] wb_data_o
);

  logic        is_mem_ph;
  logic        load_q;
  logic        word_q;
  logic        hi_q;
  logic [31:0] word_sel;

  assign is_mem_ph = (phase_i == PH_MEM);

  assign dmem_ren_o   = is_mem_ph && (mem_kind_i == MEM_LD || mem_kind_i == MEM_LW);
  assign dmem_wen_o   = is_mem_ph && (mem_kind_i == MEM_SD || mem_kind_i == MEM_SW);
  assign dmem_addr_o  = addr_i;
  // word stores go out on both halves, the mask picks one
  assign dmem_wdata_o = (mem_kind_i == MEM_SW) ? {2{store_data_i[31:0]}} : store_data_i;
  assign dmem_wmask_o = (mem_kind_i == MEM_SD) ? 8'hFF :
                        (mem_kind_i == MEM_SW) ? (addr_i[2] ? 8'hF0 : 8'h0F) : 8'h00;

  // remember how to shape the returning data
  always_ff @(posedge clock) begin
    if (reset) begin
      load_q <= 1'b0;
    end else if (is_mem_ph) begin
      load_q <= dmem_ren_o;
    end
  end

  always_ff @(posedge clock) begin
    if (is_mem_ph) begin
      word_q <= (mem_kind_i == MEM_LW);
      hi_q   <= addr_i[2];
    end
  end

  assign word_sel = hi_q ? dmem_rdata_i[63:32] : dmem_rdata_i[31:0];

  assign wb_wen_o  = rd_wen_i;
  assign wb_data_o = !load_q ? alu_result_i :
                     word_q  ? {{32{word_sel[31]}}, word_sel} : dmem_rdata_i;

  a_wmask_set: assert property (@(posedge clock) disable iff (reset)
    dmem_wen_o |-> dmem_wmask_o != 8'h00 && !dmem_ren_o);

  // the phase after a request must not issue another one
  a_one_req: assert property (@(posedge clock) disable iff (reset)
    (dmem_ren_o || dmem_wen_o) |=> !(dmem_ren_o || dmem_wen_o));

endmodule

// File: core/regfile.sv
// x0 is hardwired to zero; writes land only at the end of write-back
`timescale 1ns/1ps

module regfile import core_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic [REG_AW-1:0] rs1_i,
  input  logic [REG_AW-1:0] rs2_i,
  output logic [XLEN-1:0]   rs1_data_o,
  output logic [XLEN-1:0]   rs2_data_o,
  input  logic              wen_i,
  input  logic [REG_AW-1:0] rd_i,
  input  logic [XLEN-1:0]   wdata_i,
  input  logic              wb_phase_i,
  output logic [7:0]        x10_o
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (wb_phase_i && wen_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  // trap code source
  assign x10_o = regs[10][7:0];

  a_x0_zero: assert property (@(posedge clock) disable iff (reset)
    (rs1_i == '0 |-> rs1_data_o == '0) and (rs2_i == '0 |-> rs2_data_o == '0));

endmodule

// File: logic/sim_top.sv
// single-issue multi-cycle core, one commit per five cycles; memories sit outside
`timescale 1ns/1ps

module sim_top import core_pkg::*; #(
  parameter logic [XLEN-1:0] PC_START = 64'h0000_0000_8000_0000
) (
  input  logic            clock,
  input  logic            reset,
  output logic [XLEN-1:0] imem_addr_o,
  input  logic [31:0]     imem_data_i,
  output logic            dmem_ren_o,
  output logic            dmem_wen_o,
  output logic [XLEN-1:0] dmem_addr_o,
  output logic [XLEN-1:0] dmem_wdata_o,
  output logic [7:0]      dmem_wmask_o,
  input  logic [XLEN-1:0] dmem_rdata_i,
  output logic            cmt_valid_o,
  output logic [XLEN-1:0] cmt_pc_o,
  output logic [31:0]     cmt_inst_o,
  output logic            cmt_wen_o,
  output logic [7:0]      cmt_wdest_o,
  output logic [XLEN-1:0] cmt_wdata_o,
  output logic            trap_o,
  output logic [7:0]      trap_code_o
);

  phase_e            phase;
  logic              wb_phase, halted;
  logic [XLEN-1:0]   pc;
  inst_word_u        inst;
  logic [REG_AW-1:0] rs1, rs2, rd;
  logic [XLEN-1:0]   rs1_data, rs2_data;
  alu_op_e           alu_op;
  logic [XLEN-1:0]   op_a, op_b, store_data, imm;
  logic [2:0]        mem_kind;
  logic              is_branch, is_jal, rd_wen, trap_dec;
  logic [XLEN-1:0]   ex_result, br_target;
  logic              br_taken;
  logic              wb_wen;
  logic [XLEN-1:0]   wb_data;
  logic [7:0]        x10_low;

  phase_ctrl u_phase_ctrl (
    .clock      (clock),
    .reset      (reset),
    .trap_dec_i (trap_dec),
    .phase_o    (phase),
    .wb_phase_o (wb_phase),
    .halted_o   (halted)
  );

  if_stage #(.PC_START(PC_START)) u_if_stage (
    .clock       (clock),
    .reset       (reset),
    .phase_i     (phase),
    .br_taken_i  (br_taken),
    .br_target_i (br_target),
    .imem_data_i (imem_data_i),
    .imem_addr_o (imem_addr_o),
    .pc_o        (pc),
    .inst_o      (inst)
  );

  id_stage u_id_stage (
    .clock        (clock),
    .reset        (reset),
    .phase_i      (phase),
    .inst_i       (inst),
    .pc_i         (pc),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rd_o         (rd),
    .alu_op_o     (alu_op),
    .op_a_o       (op_a),
    .op_b_o       (op_b),
    .store_data_o (store_data),
    .imm_o        (imm),
    .mem_kind_o   (mem_kind),
    .is_branch_o  (is_branch),
    .is_jal_o     (is_jal),
    .rd_wen_o     (rd_wen),
    .trap_o       (trap_dec)
  );

  exe_stage u_exe_stage (
    .clock       (clock),
    .reset       (reset),
    .phase_i     (phase),
    .alu_op_i    (alu_op),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .imm_i       (imm),
    .pc_i        (pc),
    .is_branch_i (is_branch),
    .is_jal_i    (is_jal),
    .funct3_i    (inst.i.funct3),
    .result_o    (ex_result),
    .br_taken_o  (br_taken),
    .br_target_o (br_target)
  );

  mem_stage u_mem_stage (
    .clock        (clock),
    .reset        (reset),
    .phase_i      (phase),
    .mem_kind_i   (mem_kind),
    .addr_i       (ex_result),
    .store_data_i (store_data),
    .alu_result_i (ex_result),
    .rd_wen_i     (rd_wen),
    .dmem_ren_o   (dmem_ren_o),
    .dmem_wen_o   (dmem_wen_o),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_wmask_o (dmem_wmask_o),
    .dmem_rdata_i (dmem_rdata_i),
    .wb_wen_o     (wb_wen),
    .wb_data_o    (wb_data)
  );

  regfile u_regfile (
    .clock      (clock),
    .reset      (reset),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wen_i      (wb_wen),
    .rd_i       (rd),
    .wdata_i    (wb_data),
    .wb_phase_i (wb_phase),
    .x10_o      (x10_low)
  );

  // commit report, captured on the same edge as the register write
  always_ff @(posedge clock) begin
    if (reset) begin
      cmt_valid_o <= 1'b0;
      trap_code_o <= 8'd0;
    end else begin
      cmt_valid_o <= wb_phase;
      if (wb_phase && trap_dec) trap_code_o <= x10_low;
    end
  end

  always_ff @(posedge clock) begin
    if (wb_phase) begin
      cmt_pc_o    <= pc;
      cmt_inst_o  <= inst;
      cmt_wen_o   <= wb_wen;
      cmt_wdest_o <= {3'd0, rd};
      cmt_wdata_o <= wb_data;
    end
  end

  assign trap_o = halted;

endmodule

// File: tb/tb_mem_model.sv
// instruction ROM filled by the testbench through hierarchy; data RAM covers 64 doublewords only
`timescale 1ns/1ps

module tb_mem_model import core_pkg::*; #(
  parameter logic [XLEN-1:0] PC_START  = 64'h0000_0000_8000_0000,
  parameter int              ROM_WORDS = 32
) (
  input  logic            clock,
  input  logic [XLEN-1:0] imem_addr_i,
  output logic [31:0]     imem_data_o,
  input  logic            dmem_ren_i,
  input  logic            dmem_wen_i,
  input  logic [XLEN-1:0] dmem_addr_i,
  input  logic [XLEN-1:0] dmem_wdata_i,
  input  logic [7:0]      dmem_wmask_i,
  output logic [XLEN-1:0] dmem_rdata_o
);

  logic [31:0]     rom [ROM_WORDS];
  logic [XLEN-1:0] ram [64];
  logic [XLEN-1:0] rom_off;
  int              k;

  initial begin
    dmem_rdata_o = '0;
    for (k = 0; k < ROM_WORDS; k++) begin
      rom[k] = {25'd0, OPC_OPIMM};
    end
    // pattern built from the full doubleword index
    for (k = 0; k < 64; k++) begin
      ram[k] = {16'hC0DE, k[15:0], ~k[15:0], 16'h5A5A};
    end
  end

  // combinational fetch, out of range reads as a nop
  assign rom_off     = (imem_addr_i - PC_START) >> 2;
  assign imem_data_o = (rom_off < ROM_WORDS) ? rom[rom_off[4:0]] : {25'd0, OPC_OPIMM};

  always @(posedge clock) begin
    if (dmem_ren_i) begin
      dmem_rdata_o <= ram[dmem_addr_i[8:3]];
    end
    if (dmem_wen_i) begin
      for (int b = 0; b < 8; b++) begin
        if (dmem_wmask_i[b]) begin
          ram[dmem_addr_i[8:3]][b*8 +: 8] <= dmem_wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

// File: tb/tb_sim_top.sv
// drives sim_top with a fixed program ending in a trap; expected values come from a shadow ISA model
`timescale 1ns/1ps

module tb_sim_top;
  import core_pkg::*;

  localparam logic [63:0] PC_START = 64'h0000_0000_8000_0000;
  localparam int          PROG_LEN = 24;
  localparam int          N_TESTS  = 6;

  logic        clock;
  logic        reset;
  logic [63:0] imem_addr, dmem_addr, dmem_wdata, dmem_rdata;
  logic [63:0] cmt_pc, cmt_wdata;
  logic [31:0] imem_data, cmt_inst;
  logic [7:0]  dmem_wmask, cmt_wdest, trap_code;
  logic        dmem_ren, dmem_wen, cmt_valid, cmt_wen, trap;

  logic [31:0] prog [PROG_LEN];
  logic [63:0] sreg [32];
  logic [63:0] sdm  [64];
  logic [63:0] spc;
  logic [7:0]  last_mask;
  integer      seed;
  int          errs [N_TESTS];
  int          checks [N_TESTS];
  string       names [N_TESTS];
  int          cyc, last_cmt, n_cmt, i;
  bit          trap_seen;

  sim_top #(.PC_START(PC_START)) sim_top_i (
    .clock(clock), .reset(reset),
    .imem_addr_o(imem_addr), .imem_data_i(imem_data),
    .dmem_ren_o(dmem_ren), .dmem_wen_o(dmem_wen), .dmem_addr_o(dmem_addr),
    .dmem_wdata_o(dmem_wdata), .dmem_wmask_o(dmem_wmask), .dmem_rdata_i(dmem_rdata),
    .cmt_valid_o(cmt_valid), .cmt_pc_o(cmt_pc), .cmt_inst_o(cmt_inst),
    .cmt_wen_o(cmt_wen), .cmt_wdest_o(cmt_wdest), .cmt_wdata_o(cmt_wdata),
    .trap_o(trap), .trap_code_o(trap_code)
  );

  tb_mem_model #(.PC_START(PC_START), .ROM_WORDS(32)) mem_i (
    .clock(clock), .imem_addr_i(imem_addr), .imem_data_o(imem_data),
    .dmem_ren_i(dmem_ren), .dmem_wen_i(dmem_wen), .dmem_addr_i(dmem_addr),
    .dmem_wdata_i(dmem_wdata), .dmem_wmask_i(dmem_wmask), .dmem_rdata_o(dmem_rdata)
  );

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  task automatic check_val(input int id, input string what, input logic [63:0] exp,
                           input logic [63:0] act);
    checks[id]++;
    assert (act === exp) else begin
      $display("Error %s %s: expected %h actual %h", names[id], what, exp, act);
      errs[id]++;
    end
  endtask

  task automatic note_fail(input int id, input string msg);
    errs[id]++;
    $display("%s: %s", names[id], msg);
  endtask

  // shadow ISA step for one committed instruction
  task automatic shadow_commit();
    logic [31:0] w;
    logic [63:0] a, b, res, addr, npc, imm_i, imm_s, imm_b, imm_j;
    logic [31:0] half;
    logic [4:0]  rd;
    logic        wen;
    int          id;
    w     = prog[(spc - PC_START) >> 2];
    a     = sreg[w[19:15]];
    b     = sreg[w[24:20]];
    rd    = w[11:7];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    npc   = spc + 64'd4;
    res   = 64'd0;
    wen   = 1'b0;
    id    = 1;
    case (w[6:0])
      OPC_OP: begin
        wen = 1'b1;
        case (w[14:12])
          3'b000: res = w[30] ? a - b : a + b;
          3'b010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          3'b100: res = a ^ b;
          3'b110: res = a | b;
          default: res = a & b;
        endcase
      end
      OPC_OPIMM: begin
        wen = 1'b1;
        res = a + imm_i;
        if (rd == 5'd0) id = 4;
      end
      OPC_LOAD: begin
        id   = 2;
        wen  = 1'b1;
        addr = a + imm_i;
        res  = sdm[addr[8:3]];
        half = addr[2] ? res[63:32] : res[31:0];
        if (w[14:12] == 3'b010) res = {{32{half[31]}}, half};
      end
      OPC_STORE: begin
        id   = 2;
        addr = a + imm_s;
        if (w[14:12] == 3'b011) begin
          sdm[addr[8:3]] = b;
          check_val(2, "sd mask", 64'hFF, {56'd0, last_mask});
        end else begin
          if (addr[2]) sdm[addr[8:3]][63:32] = b[31:0];
          else sdm[addr[8:3]][31:0] = b[31:0];
          check_val(2, "sw mask", addr[2] ? 64'hF0 : 64'h0F, {56'd0, last_mask});
        end
      end
      OPC_BRANCH: begin
        id = 3;
        if ((w[14:12] == 3'b000) == (a == b)) npc = spc + imm_b;
      end
      OPC_JAL: begin
        id  = 3;
        wen = 1'b1;
        res = spc + 64'd4;
        npc = spc + imm_j;
      end
      OPC_TRAP: begin
        id = 5;
        check_val(5, "trap_o", 64'd1, {63'd0, trap});
        check_val(5, "trap code", {56'd0, sreg[10][7:0]}, {56'd0, trap_code});
        trap_seen = 1'b1;
      end
      default: ;
    endcase
    if (rd == 5'd0) wen = 1'b0;
    check_val(3, "commit pc", spc, cmt_pc);
    check_val(4, "commit inst", {32'd0, w}, {32'd0, cmt_inst});
    check_val(4, "commit wen", {63'd0, wen}, {63'd0, cmt_wen});
    if (wen) begin
      check_val(id, "wdest", {59'd0, rd}, {56'd0, cmt_wdest});
      check_val(id, "wdata", res, cmt_wdata);
      sreg[rd] = res;
    end
    spc = npc;
  endtask

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    #((PROG_LEN * 5 + 10 + 60) * 40);
    $display("watchdog: the core never reached its trap within the time limit");
    $display("STATUS: FAIL");
    $finish;
  end

  always @(posedge clock) begin
    cyc <= cyc + 1;
    if (dmem_wen) last_mask <= dmem_wmask;
  end

  always @(posedge clock) begin
    if (!reset) begin
      if (trap_seen && (cmt_valid || dmem_ren || dmem_wen)) begin
        note_fail(5, "a commit or data request appeared after the trap");
      end else if (cmt_valid) begin
        if (n_cmt == 0) begin
          check_val(0, "first pc", PC_START, cmt_pc);
        end else begin
          check_val(4, "commit spacing", 64'd5, 64'(cyc - last_cmt));
        end
        last_cmt = cyc;
        n_cmt++;
        shadow_commit();
      end
    end
  end

  a_cmt_gap: assert property (@(posedge clock) disable iff (reset)
    (cmt_valid && !trap) |=> !cmt_valid ##1 !cmt_valid ##1 !cmt_valid ##1 !cmt_valid
    ##1 cmt_valid)
    else note_fail(4, "commit pulses were not five cycles apart");

  a_trap_quiet: assert property (@(posedge clock) disable iff (reset)
    trap |-> !dmem_ren && !dmem_wen)
    else note_fail(5, "data port active while halted");

  initial begin
    int failed;
    reset     = 1'b1;
    seed      = 32'h2385;
    trap_seen = 1'b0;
    cyc       = 0;
    n_cmt     = 0;
    last_cmt  = 0;
    last_mask = 8'd0;
    spc       = PC_START;
    names     = '{"reset", "alu", "memory", "control", "commit", "trap"};
    for (i = 0; i < N_TESTS; i++) begin
      errs[i]   = 0;
      checks[i] = 0;
    end
    for (i = 0; i < 32; i++) sreg[i] = 64'd0;
    for (i = 0; i < 64; i++) sdm[i] = {16'hC0DE, i[15:0], ~i[15:0], 16'h5A5A};

    prog[0]  = enc_i(12'($random(seed)), 5'd0, 3'b000, 5'd1, OPC_OPIMM);
    prog[1]  = enc_i(12'($random(seed)), 5'd0, 3'b000, 5'd2, OPC_OPIMM);
    prog[2]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
    prog[3]  = enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);
    prog[4]  = enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);
    prog[5]  = enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);
    prog[6]  = enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);
    prog[7]  = enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8);
    prog[8]  = enc_i(12'($random(seed)), 5'd1, 3'b000, 5'd9, OPC_OPIMM);
    prog[9]  = enc_s(12'h100, 5'd3, 5'd0, 3'b011);
    prog[10] = enc_i(12'h100, 5'd0, 3'b011, 5'd11, OPC_LOAD);
    prog[11] = enc_s(12'h108, 5'd4, 5'd0, 3'b010);
    prog[12] = enc_s(12'h10c, 5'd1, 5'd0, 3'b010);
    prog[13] = enc_i(12'h10c, 5'd0, 3'b010, 5'd12, OPC_LOAD);
    prog[14] = enc_i(12'h108, 5'd0, 3'b010, 5'd13, OPC_LOAD);
    prog[15] = enc_b(13'd8, 5'd1, 5'd1, 3'b000);
    prog[16] = enc_i(12'd1, 5'd0, 3'b000, 5'd14, OPC_OPIMM);
    prog[17] = enc_b(13'd8, 5'd1, 5'd1, 3'b001);
    prog[18] = enc_i(12'd7, 5'd0, 3'b000, 5'd15, OPC_OPIMM);
    prog[19] = enc_j(21'd8, 5'd16);
    prog[20] = enc_i(12'd3, 5'd0, 3'b000, 5'd17, OPC_OPIMM);
    prog[21] = enc_i(12'd5, 5'd1, 3'b000, 5'd0, OPC_OPIMM);
    prog[22] = enc_i(12'($random(seed)), 5'd0, 3'b000, 5'd10, OPC_OPIMM);
    prog[23] = {25'd0, OPC_TRAP};

    repeat (10) @(posedge clock);
    // ROM default fill is done by now, the program goes in on top
    for (i = 0; i < PROG_LEN; i++) mem_i.rom[i] = prog[i];
    #1 reset = 1'b0;
    check_val(0, "cmt_valid", 64'd0, {63'd0, cmt_valid});
    check_val(0, "trap_o", 64'd0, {63'd0, trap});
    check_val(0, "dmem enables", 64'd0, {62'd0, dmem_ren, dmem_wen});

    wait (trap_seen);
    // let the halted core sit for a while
    repeat (20) @(posedge clock);
    #1;
    if (n_cmt != PROG_LEN - 2) note_fail(3, "commit count differs from the shadow path");

    failed = 0;
    for (i = 0; i < N_TESTS; i++) begin
      $display("test %-8s %s (%0d checks, %0d errors)", names[i],
               errs[i] == 0 ? "ok" : "failed", checks[i], errs[i]);
      if (errs[i] != 0) failed++;
    end
    $display("tests run %0d, passed %0d, failed %0d", N_TESTS, N_TESTS - failed, failed);
    if (failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
common/core_pkg.sv
logic/phase_ctrl.sv
core/if_stage.sv
core/id_stage.sv
core/exe_stage.sv
core/mem_stage.sv
core/regfile.sv
logic/sim_top.sv
tb/tb_mem_model.sv
tb/tb_sim_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sim_top
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= STATUS: PASS

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -F "$(PASS_STR)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
